/* design/photon_pkg.sv */
package photon_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Measurement types.
    ////////////////////////////////////////////////////////////////////////////

    // Photon count for one sync period.
    // It wraps modulo 2^16.
    typedef logic [15:0] count_t;

    // One UART payload byte.
    typedef logic [7:0] byte_t;

    ////////////////////////////////////////////////////////////////////////////
    // UART framing.
    ////////////////////////////////////////////////////////////////////////////

    // 133.33 MHz / 115200 baud, rounded.
    localparam int BAUD_DIV_DEFAULT = 1157;

    // Start, eight data bits, stop.
    localparam int UART_FRAME_BITS = 10;

    // Bytes per reported word.
    // The high byte goes out first.
    localparam int BYTES_PER_COUNT = 2;

    // Line level while idle and during stop.
    localparam logic UART_IDLE_LEVEL = 1'b1;

endpackage

/* design/mem_bus_pkg.sv */
package mem_bus_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Count memory bus.
    ////////////////////////////////////////////////////////////////////////////

    // Ring slot address, sized for the largest ring.
    typedef logic [9:0] mem_addr_t;

    // Ring pointer, one bit wider than the slot address.
    // The top bit separates full from empty.
    typedef logic [10:0] ring_ptr_t;

    // Owner of the single memory port.
    typedef enum logic {
        REQ_WRITER = 1'b0, // History writer.
        REQ_READER = 1'b1  // UART reporter.
    } requester_t;

    ////////////////////////////////////////////////////////////////////////////
    // Ring sizing.
    ////////////////////////////////////////////////////////////////////////////

    // Full array, 1024 slots.
    localparam int RING_DEPTH_DEFAULT = 1024;

    // Slots in the storage array.
    localparam int MEM_WORDS = 1024;

endpackage

/* design/photon_counter.sv */
module photon_counter (
    input  logic               clk_133MHz_210,
    input  logic               rst_n,
    input  logic               photon_pulse,   // Async pin.
    input  logic               sync_50Hz,      // Async pin.
    input  logic               count_ready,
    output logic               count_valid,
    output photon_pkg::count_t count,
    output logic               overrun         // Sticky.
);
    import photon_pkg::*;

    logic [2:0] photon_sr;   // Two sync flops then the edge register.
    logic [2:0] sync_sr;
    logic       photon_rise;
    logic       sync_rise;
    logic       primed;      // A sync edge has opened a period.
    logic       period_end;
    count_t     period_cnt;  // Running count of the current period.

    assign photon_rise = photon_sr[1] & ~photon_sr[2];
    assign sync_rise   = sync_sr[1] & ~sync_sr[2];
    // The first sync edge after reset only opens a period.
    assign period_end  = sync_rise & primed;

    ////////////////////////////////////////////////////////////////////////////
    // Synchronizers, period counter and output handshake.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            photon_sr   <= '0;
            sync_sr     <= '0;
            period_cnt  <= '0;
            primed      <= 1'b0;
            count_valid <= 1'b0;
            overrun     <= 1'b0;
        end else begin
            photon_sr <= {photon_sr[1:0], photon_pulse};
            sync_sr   <= {sync_sr[1:0], sync_50Hz};
            if (sync_rise) begin
                primed     <= 1'b1;
                period_cnt <= count_t'(photon_rise); // Same-cycle photon is new period.
            end else if (photon_rise) begin
                period_cnt <= period_cnt + 1'b1;     // Wraps.
            end
            if (period_end) begin
                count_valid <= 1'b1;
                if (count_valid && !count_ready) begin
                    overrun <= 1'b1;                 // Pending result lost.
                end
            end else if (count_ready) begin
                count_valid <= 1'b0;                 // Taken by the writer.
            end
        end
    end

    // Latch the closed period.
    always_ff @(posedge clk_133MHz_210) begin
        if (period_end) begin
            count <= period_cnt;
        end
    end

    // A waiting result stays put unless an overrun replaced it.
    a_count_hold: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        count_valid && !count_ready |=> count_valid && ($stable(count) || overrun));

endmodule

/* design/history_writer.sv */
module history_writer #(
    parameter int RING_DEPTH = mem_bus_pkg::RING_DEPTH_DEFAULT // Power of two.
) (
    input  logic                   clk_133MHz_210,
    input  logic                   rst_n,
    input  logic                   count_valid,
    input  photon_pkg::count_t     count,
    input  mem_bus_pkg::ring_ptr_t rd_ptr,
    input  logic                   wr_done,
    output logic                   count_ready,
    output logic                   wr_req,
    output mem_bus_pkg::mem_addr_t wr_addr,
    output photon_pkg::count_t     wr_data,
    output mem_bus_pkg::ring_ptr_t wr_ptr
);
    import mem_bus_pkg::*;

    localparam mem_addr_t SLOT_MASK = mem_addr_t'(RING_DEPTH - 1);

    ring_ptr_t fill; // Entries not yet read back.

    assign fill        = wr_ptr - rd_ptr;
    assign count_ready = !wr_req && (fill < ring_ptr_t'(RING_DEPTH));
    assign wr_addr     = mem_addr_t'(wr_ptr) & SLOT_MASK; // Held with wr_req.

    // Request stays up until the arbiter returns done.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            wr_req <= 1'b0;
            wr_ptr <= '0;
        end else if (wr_req) begin
            if (wr_done) begin
                wr_req <= 1'b0;
                wr_ptr <= wr_ptr + 1'b1; // Slot now holds data.
            end
        end else if (count_valid && count_ready) begin
            wr_req <= 1'b1;
        end
    end

    // Word captured on acceptance.
    always_ff @(posedge clk_133MHz_210) begin
        if (count_valid && count_ready) begin
            wr_data <= count;
        end
    end

endmodule

/* design/mem_arbiter.sv */
module mem_arbiter (
    input  logic                   clk_133MHz_210,
    input  logic                   rst_n,
    // Write requester.
    input  logic                   wr_req,
    input  mem_bus_pkg::mem_addr_t wr_addr,
    input  photon_pkg::count_t     wr_data,
    output logic                   wr_done,
    // Read requester.
    input  logic                   rd_req,
    input  mem_bus_pkg::mem_addr_t rd_addr,
    output logic                   rd_done,
    output photon_pkg::count_t     rd_data,
    // Memory port.
    output logic                   mem_req,
    output logic                   mem_we,
    output mem_bus_pkg::mem_addr_t mem_addr,
    output photon_pkg::count_t     mem_wdata,
    input  logic                   mem_done,
    input  photon_pkg::count_t     mem_rdata
);
    import mem_bus_pkg::*;

    requester_t owner; // Current owner or the last one while free.
    logic       busy;  // Port granted and done not yet seen.

    ////////////////////////////////////////////////////////////////////////////
    // Grant FSM.
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            owner <= REQ_READER; // Writer wins the first tie.
            busy  <= 1'b0;
        end else if (busy) begin
            if (mem_done) begin
                busy <= 1'b0;    // Owner kept as last owner.
            end
        end else if (wr_req && rd_req) begin
            owner <= (owner == REQ_WRITER) ? REQ_READER : REQ_WRITER;
            busy  <= 1'b1;
        end else if (wr_req) begin
            owner <= REQ_WRITER;
            busy  <= 1'b1;
        end else if (rd_req) begin
            owner <= REQ_READER;
            busy  <= 1'b1;
        end
    end

    // Port mux.
    assign mem_req   = busy;
    assign mem_we    = busy && (owner == REQ_WRITER);
    assign mem_addr  = (owner == REQ_WRITER) ? wr_addr : rd_addr;
    assign mem_wdata = wr_data;

    // Done goes back to the owner only.
    assign wr_done = busy && mem_done && (owner == REQ_WRITER);
    assign rd_done = busy && mem_done && (owner == REQ_READER);
    assign rd_data = mem_rdata; // Valid with rd_done.

    // Every memory done reaches exactly one requester.
    a_single_done: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        mem_done |-> $onehot({wr_done, rd_done}));

endmodule

/* design/count_memory.sv */
module count_memory #(
    parameter int MEM_LATENCY = 4 // Cycles from req to done, at least 1.
) (
    input  logic                   clk_133MHz_210,
    input  logic                   rst_n,
    input  logic                   mem_req,
    input  logic                   mem_we,
    input  mem_bus_pkg::mem_addr_t mem_addr,
    input  photon_pkg::count_t     mem_wdata,
    output logic                   mem_done,
    output photon_pkg::count_t     mem_rdata
);
    import photon_pkg::*;
    import mem_bus_pkg::*;

    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    count_t           store [MEM_WORDS]; // Ring storage.
    logic [CNT_W-1:0] lat_cnt;           // Cycles since req rose.
    logic             fire;              // Access completes next cycle.

    assign fire = mem_req && !mem_done && (lat_cnt == CNT_W'(MEM_LATENCY - 1));

    // Access timer, stands in for the SDRAM.
    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt  <= '0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= fire;    // One pulse per request.
            if (mem_done) begin
                lat_cnt <= '0;   // Ready for the next request.
            end else if (mem_req) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    // Write lands at done, read data valid at done.
    always_ff @(posedge clk_133MHz_210) begin
        if (fire && mem_we) begin
            store[mem_addr] <= mem_wdata;
        end
        if (fire) begin
            mem_rdata <= store[mem_addr];
        end
    end

    a_addr_hold: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        mem_req && !mem_done |=> $stable(mem_addr));

endmodule

/* design/uart_tx.sv */
module uart_tx #(
    parameter int BAUD_DIV = photon_pkg::BAUD_DIV_DEFAULT // Cycles per bit.
) (
    input  logic              clk_133MHz_210,
    input  logic              rst_n,
    input  logic              tx_valid,
    input  photon_pkg::byte_t tx_byte,
    output logic              tx_ready,
    output logic              uart_txd
);
    import photon_pkg::*;

    localparam int BAUD_W = $clog2(BAUD_DIV + 1);
    localparam int IDX_W  = $clog2(UART_FRAME_BITS);

    logic                       busy;
    logic [BAUD_W-1:0]          baud_cnt; // Cycles into current bit.
    logic [IDX_W-1:0]           bit_idx;  // 0 is start, last is stop.
    logic [UART_FRAME_BITS-2:0] shreg;    // Data bits, then stop.
    logic                       bit_end;

    assign bit_end  = (baud_cnt == BAUD_W'(BAUD_DIV - 1));
    assign tx_ready = !busy;

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
            uart_txd <= UART_IDLE_LEVEL;
        end else if (!busy) begin
            if (tx_valid) begin
                busy     <= 1'b1;
                baud_cnt <= '0;
                bit_idx  <= '0;
                uart_txd <= 1'b0;                           // Start bit.
            end
        end else if (bit_end) begin
            baud_cnt <= '0;
            if (bit_idx == IDX_W'(UART_FRAME_BITS - 1)) begin
                busy <= 1'b0;                               // Stop bit done.
            end else begin
                uart_txd <= shreg[0];                       // LSB first.
                bit_idx  <= bit_idx + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_133MHz_210) begin
        if (tx_valid && tx_ready) begin
            shreg <= {UART_IDLE_LEVEL, tx_byte};
        end else if (busy && bit_end) begin
            shreg <= shreg >> 1;
        end
    end

    a_idle_high: assert property (@(posedge clk_133MHz_210) disable iff (!rst_n)
        tx_ready |-> uart_txd);

endmodule

/* design/uart_reporter.sv */
module uart_reporter #(
    parameter int RING_DEPTH = mem_bus_pkg::RING_DEPTH_DEFAULT,
    parameter int BAUD_DIV   = photon_pkg::BAUD_DIV_DEFAULT
) (
    input  logic                   clk_133MHz_210,
    input  logic                   rst_n,
    input  mem_bus_pkg::ring_ptr_t wr_ptr,
    input  logic                   rd_done,
    input  photon_pkg::count_t     rd_data,
    output logic                   rd_req,
    output mem_bus_pkg::mem_addr_t rd_addr,
    output mem_bus_pkg::ring_ptr_t rd_ptr,
    output logic                   uart_txd
);
    import photon_pkg::*;
    import mem_bus_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_HIGH, ST_LOW} rep_state_t;

    localparam mem_addr_t SLOT_MASK = mem_addr_t'(RING_DEPTH - 1);

    rep_state_t state;
    count_t     word;     // Entry being sent.
    logic       tx_valid;
    logic       tx_ready;
    byte_t      tx_byte;

    assign rd_req   = (state == ST_READ);
    assign rd_addr  = mem_addr_t'(rd_ptr) & SLOT_MASK;
    assign tx_valid = (state == ST_HIGH) || (state == ST_LOW);
    assign tx_byte  = (state == ST_HIGH) ? word[15:8] : word[7:0]; // High first.

    always_ff @(posedge clk_133MHz_210 or negedge rst_n) begin
        if (!rst_n) begin
            state  <= ST_IDLE;
            rd_ptr <= '0;
        end else begin
            case (state)
                ST_IDLE: if (rd_ptr != wr_ptr) state <= ST_READ; // Unreported entry.
                ST_READ: if (rd_done) begin
                    rd_ptr <= rd_ptr + 1'b1;                    // Slot freed.
                    state  <= ST_HIGH;
                end
                ST_HIGH: if (tx_ready) state <= ST_LOW;
                ST_LOW:  if (tx_ready) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_133MHz_210) begin
        if (state == ST_READ && rd_done) begin
            word <= rd_data;
        end
    end

    uart_tx #(.BAUD_DIV(BAUD_DIV)) i_uart_tx (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .tx_valid       (tx_valid),
        .tx_byte        (tx_byte),
        .tx_ready       (tx_ready),
        .uart_txd       (uart_txd)
    );

endmodule

/* design/spc_top.sv */
module spc_top #(
    parameter int BAUD_DIV    = photon_pkg::BAUD_DIV_DEFAULT,
    parameter int RING_DEPTH  = mem_bus_pkg::RING_DEPTH_DEFAULT, // Power of two, max 1024.
    parameter int MEM_LATENCY = 4
) (
    input  logic clk_133MHz_210,
    input  logic rst_n,
    input  logic photon_pulse,
    input  logic sync_50Hz,
    output logic uart_txd,
    output logic overrun
);
    import photon_pkg::*;
    import mem_bus_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Counter to writer.
    logic      count_valid;
    logic      count_ready;
    count_t    count;
    // Requesters to arbiter.
    logic      wr_req, wr_done, rd_req, rd_done;
    mem_addr_t wr_addr, rd_addr;
    count_t    wr_data, rd_data;
    ring_ptr_t wr_ptr, rd_ptr;
    // Arbiter to memory.
    logic      mem_req, mem_we, mem_done;
    mem_addr_t mem_addr;
    count_t    mem_wdata, mem_rdata;
    ////////////////////////////////////////////////////////////////////////////

    photon_counter i_counter (
        .clk_133MHz_210, .rst_n, .photon_pulse, .sync_50Hz,
        .count_ready, .count_valid, .count, .overrun
    );

    history_writer #(.RING_DEPTH(RING_DEPTH)) i_writer (
        .clk_133MHz_210, .rst_n, .count_valid, .count, .rd_ptr, .wr_done,
        .count_ready, .wr_req, .wr_addr, .wr_data, .wr_ptr
    );

    uart_reporter #(.RING_DEPTH(RING_DEPTH), .BAUD_DIV(BAUD_DIV)) i_reporter (
        .clk_133MHz_210, .rst_n, .wr_ptr, .rd_done, .rd_data,
        .rd_req, .rd_addr, .rd_ptr, .uart_txd
    );

    mem_arbiter i_arbiter (
        .clk_133MHz_210, .rst_n,
        .wr_req, .wr_addr, .wr_data, .wr_done,
        .rd_req, .rd_addr, .rd_done, .rd_data,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_done, .mem_rdata
    );

    count_memory #(.MEM_LATENCY(MEM_LATENCY)) i_memory (
        .clk_133MHz_210, .rst_n, .mem_req, .mem_we, .mem_addr, .mem_wdata,
        .mem_done, .mem_rdata
    );

endmodule

/* include/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Run totals.
int          check_count = 0;
int          error_count = 0;
int          test_count  = 0;
int unsigned lcg_state   = 32'd77; // Seed.

////////////////////////////////////////////////////////////////////////////
// Value check.
////////////////////////////////////////////////////////////////////////////
task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
        error_count++;
        $display("FAIL t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp);
    end
endtask

// LCG step, result in 0 .. limit-1.
function automatic int unsigned next_rand(input int unsigned limit);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return (lcg_state >> 16) % limit; // Upper bits, better spread.
endfunction

////////////////////////////////////////////////////////////////////////////
// UART byte receiver, sampled at mid-bit on the falling clock edge.
////////////////////////////////////////////////////////////////////////////
task automatic receive_byte(output byte_t data);
    int waited = 0;
    data = '0;
    do begin
        @(negedge clk_133MHz_210);  // Hunt for the start bit.
        waited++;
    end while (uart_txd !== 1'b0 && waited < START_WAIT_CYCLES);
    if (uart_txd !== 1'b0) begin
        error_count++;
        $display("ERROR t=%0t no start bit on uart_txd within %0d cycles",
                 $time, START_WAIT_CYCLES);
        return;
    end
    repeat (BIT_CYCLES / 2) @(negedge clk_133MHz_210); // Middle of start.
    if (uart_txd !== 1'b0) begin
        error_count++;
        $display("ERROR t=%0t start bit on uart_txd too short", $time);
    end
    for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYCLES) @(negedge clk_133MHz_210);
        data[i] = uart_txd;         // LSB first.
    end
    repeat (BIT_CYCLES) @(negedge clk_133MHz_210);
    if (uart_txd !== 1'b1) begin
        error_count++;
        $display("ERROR t=%0t stop bit on uart_txd is low", $time);
    end
endtask

`endif

/* tb/tb_spc_top.sv */
module tb_spc_top;
    import photon_pkg::*;

    localparam int CLK_PERIOD        = 20;
    localparam int BIT_CYCLES        = 8;    // DUT BAUD_DIV.
    localparam int RING_DEPTH        = 8;
    localparam int MEM_LATENCY       = 4;
    localparam int START_WAIT_CYCLES = 2000; // Receiver gives up after this.
    localparam int MAX_PULSES        = 40;
    localparam int RAND_PERIODS      = 12;
    localparam int BURST_SYNCS       = 11;

    ////////////////////////////////////////////////////////////////////////////
    // Watchdog budget.
    ////////////////////////////////////////////////////////////////////////////
    localparam int FRAMES        = 2 + 4 + 2 * RAND_PERIODS + 2;
    localparam int DRIVE_CYCLES  = 3 + 200 + (10 + 5 * 8 + 10) + 2 * 10
                                 + RAND_PERIODS * (MAX_PULSES * 8 + 10)
                                 + BURST_SYNCS * 10 + 4;
    localparam longint TIMEOUT   = 2 * (longint'(FRAMES) * UART_FRAME_BITS
                                 * BIT_CYCLES * CLK_PERIOD
                                 + longint'(DRIVE_CYCLES) * CLK_PERIOD);

    logic clk_133MHz_210 = 1'b0;
    logic rst_n          = 1'b0;
    logic photon_pulse   = 1'b0;
    logic sync_50Hz      = 1'b0;
    logic uart_txd;
    logic overrun;
    int   test_errors;              // Error count when the test began.

    `include "tb_checks.svh"

    spc_top #(
        .BAUD_DIV    (BIT_CYCLES),
        .RING_DEPTH  (RING_DEPTH),
        .MEM_LATENCY (MEM_LATENCY)
    ) i_dut (
        .clk_133MHz_210 (clk_133MHz_210),
        .rst_n          (rst_n),
        .photon_pulse   (photon_pulse),
        .sync_50Hz      (sync_50Hz),
        .uart_txd       (uart_txd),
        .overrun        (overrun)
    );

    always #(CLK_PERIOD / 2) clk_133MHz_210 = ~clk_133MHz_210;

    initial begin
        #(TIMEOUT);
        $display("ERROR t=%0t watchdog expired after %0d time units", $time, TIMEOUT);
        $display("=== FAIL ===");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and bookkeeping.
    ////////////////////////////////////////////////////////////////////////////
    task automatic finish_test(input string name);
        test_count++;
        if (error_count == test_errors) begin
            $display("test %0d %s: ok", test_count, name);
        end else begin
            $display("test %0d %s: %0d errors", test_count, name, error_count - test_errors);
        end
    endtask

    // Photon pulses, 4 high then 4 low.
    task automatic send_pulses(input int n);
        for (int i = 0; i < n; i++) begin
            photon_pulse <= 1'b1;
            repeat (4) @(posedge clk_133MHz_210);
            photon_pulse <= 1'b0;
            repeat (4) @(posedge clk_133MHz_210);
        end
    endtask

    // Sync pulse, rising 6 cycles after the last photon fell.
    task automatic send_sync();
        repeat (2) @(posedge clk_133MHz_210);
        sync_50Hz <= 1'b1;
        repeat (4) @(posedge clk_133MHz_210);
        sync_50Hz <= 1'b0;
        repeat (4) @(posedge clk_133MHz_210);
    endtask

    task automatic receive_word(output count_t word);
        byte_t hi;
        byte_t lo;
        receive_byte(hi);           // High byte first.
        receive_byte(lo);
        word = {hi, lo};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests.
    ////////////////////////////////////////////////////////////////////////////
    task automatic test_reset_state();
        bit line_idle = 1'b1;
        test_errors = error_count;
        @(negedge clk_133MHz_210);
        check_value("uart_txd", uart_txd, 1);
        check_value("overrun", overrun, 0);
        repeat (200) begin
            @(negedge clk_133MHz_210);
            if (uart_txd !== 1'b1) line_idle = 1'b0;
        end
        if (!line_idle) begin
            error_count++;
            $display("ERROR t=%0t a UART frame started with no input", $time);
        end
        @(posedge clk_133MHz_210);  // Back on the drive edge.
        finish_test("reset state");
    endtask

    task automatic test_single_period();
        byte_t hi;
        byte_t lo;
        test_errors = error_count;
        fork
            begin
                send_sync();        // Opens the period.
                send_pulses(5);
                send_sync();        // Closes it.
            end
            begin
                receive_byte(hi);
                receive_byte(lo);
            end
        join
        @(negedge clk_133MHz_210);
        check_value("rx_byte_high", hi, 8'h00);
        check_value("rx_byte_low", lo, 8'h05);
        @(posedge clk_133MHz_210);
        finish_test("single period");
    endtask

    task automatic test_empty_periods();
        count_t w0;
        count_t w1;
        test_errors = error_count;
        fork
            begin
                send_sync();
                send_sync();
            end
            begin
                receive_word(w0);
                receive_word(w1);
            end
        join
        @(negedge clk_133MHz_210);
        check_value("rx_word 0", w0, 0);
        check_value("rx_word 1", w1, 0);
        @(posedge clk_133MHz_210);
        finish_test("empty periods");
    endtask

    task automatic test_random_periods();
        int     n;
        count_t word;
        test_errors = error_count;
        for (int p = 0; p < RAND_PERIODS; p++) begin
            n = next_rand(MAX_PULSES + 1);
            fork
                begin
                    send_pulses(n);
                    send_sync();
                end
                receive_word(word);
            join
            @(negedge clk_133MHz_210);
            check_value($sformatf("rx_word %0d", p), word, n);
            @(posedge clk_133MHz_210);
        end
        finish_test("random periods");
    endtask

    task automatic test_overrun();
        count_t word;
        test_errors = error_count;
        fork
            begin
                for (int s = 0; s < BURST_SYNCS; s++) begin
                    photon_pulse <= 1'b1;       // One photon per period.
                    repeat (4) @(posedge clk_133MHz_210);
                    photon_pulse <= 1'b0;
                    sync_50Hz    <= 1'b1;
                    repeat (4) @(posedge clk_133MHz_210);
                    sync_50Hz    <= 1'b0;
                    repeat (2) @(posedge clk_133MHz_210);
                end
                repeat (4) @(posedge clk_133MHz_210); // Last edge clears the synchronizer.
            end
            receive_word(word);
        join
        @(negedge clk_133MHz_210);
        check_value("overrun", overrun, 1);
        check_value("rx_word", word, 1);
        @(posedge clk_133MHz_210);
        finish_test("overrun");
    endtask

    initial begin
        repeat (3) @(posedge clk_133MHz_210);
        rst_n <= 1'b1;
        @(posedge clk_133MHz_210);
        test_reset_state();
        test_single_period();
        test_empty_periods();
        test_random_periods();
        test_overrun();
        $display("tests=%0d checks=%0d errors=%0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+include
design/photon_pkg.sv
design/mem_bus_pkg.sv
design/photon_counter.sv
design/history_writer.sv
design/mem_arbiter.sv
design/count_memory.sv
design/uart_tx.sv
design/uart_reporter.sv
design/spc_top.sv
tb/tb_spc_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --timing --assert
TOP       := tb_spc_top
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
